/* src/image_buffer_pkg.sv */
`default_nettype none

package image_buffer_pkg;

    // Capacity of the frame buffer
    localparam int words_per_buffer = 16384;  // RAM depth in 32-bit words
    localparam int bytes_per_buffer = 65536;  // Size saturates here

    // One byte from the encoder or to the host
    typedef logic [7:0] byte_t;

    // Four bytes packed, lane 0 in the low bits
    typedef logic [31:0] word_t;

    // RAM word address
    typedef logic [13:0] word_addr_t;

    // Host byte address, upper 14 bits select the word
    typedef logic [15:0] byte_addr_t;

    // Byte position inside a word
    typedef logic [1:0] lane_t;

    // One extra bit so a full buffer still fits
    typedef logic [16:0] image_size_t;

endpackage

`default_nettype wire

/* src/word_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module word_packer
    import image_buffer_pkg::*;
(
    input  logic       clock_in,
    input  logic       rst,
    input  logic       image_start,
    input  logic       image_end,
    input  logic       byte_valid,
    input  byte_t      byte_data,
    output logic       write_enable,
    output word_addr_t write_address,
    output word_t      write_data
);

    lane_t      lane;          // Next lane to fill
    word_addr_t word_address;  // Word being assembled
    word_t      partial_word;  // Lanes filled so far
    word_t      merged_word;   // Partial word plus the incoming byte
    logic       buffer_full;   // Last word already written

    // A new word starts from zero, so lanes never filled stay zero on a flush
    always_comb begin
        if (lane == 2'd0) begin
            merged_word = '0;
        end else begin
            merged_word = partial_word;
        end

        case (lane)
            2'd0: merged_word[7:0]   = byte_data;
            2'd1: merged_word[15:8]  = byte_data;
            2'd2: merged_word[23:16] = byte_data;
            2'd3: merged_word[31:24] = byte_data;
            default: merged_word = partial_word;
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (rst) begin
            lane         <= '0;
            word_address <= '0;
            buffer_full  <= 1'b0;
            write_enable <= 1'b0;
        end else begin
            write_enable <= 1'b0;  // Single-cycle write strobe

            if (image_start) begin
                lane         <= '0;
                word_address <= '0;
                buffer_full  <= 1'b0;
            end else if (byte_valid && !buffer_full) begin
                lane <= lane + 1'b1;  // Wraps from 3 back to 0

                if (lane == 2'd3) begin
                    write_enable <= 1'b1;
                    word_address <= word_address + 1'b1;

                    if (word_address == word_addr_t'(words_per_buffer - 1)) begin
                        buffer_full <= 1'b1;  // Address would wrap, drop the rest
                    end
                end
            end else if (image_end && lane != 2'd0 && !buffer_full) begin
                // Flush the partial last word
                lane         <= '0;
                write_enable <= 1'b1;
                word_address <= word_address + 1'b1;

                if (word_address == word_addr_t'(words_per_buffer - 1)) begin
                    buffer_full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (byte_valid && !buffer_full) begin
            partial_word <= merged_word;
        end

        // Byte strobe means a lane 3 write, otherwise a flush
        if (byte_valid) begin
            write_data <= merged_word;
        end else begin
            write_data <= partial_word;
        end

        write_address <= word_address;  // Address before the increment
    end

endmodule

`default_nettype wire

/* src/buffer_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module buffer_ram
    import image_buffer_pkg::*;
(
    input  logic       clock_in,
    input  logic       write_enable,
    input  word_addr_t write_address,
    input  word_addr_t read_address,
    input  word_t      write_data,
    output word_t      read_word
);

    word_t mem [0:words_per_buffer-1];  // Maps onto block RAM

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // Registered read, old data on a same-address write
    always_ff @(posedge clock_in) begin
        read_word <= mem[read_address];
    end

endmodule

`default_nettype wire

/* src/capture_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_tracker
    import image_buffer_pkg::*;
(
    input  logic        clock_in,
    input  logic        rst,
    input  logic        image_start,
    input  logic        image_end,
    input  logic        byte_valid,
    output image_size_t image_size,
    output logic        image_ready,
    output logic        overflow
);

    logic size_full;  // Buffer holds a full image

    assign size_full = (image_size == image_size_t'(bytes_per_buffer));

    always_ff @(posedge clock_in) begin
        if (rst) begin
            image_size  <= '0;
            image_ready <= 1'b0;
            overflow    <= 1'b0;
        end else if (image_start) begin
            // New image, forget the previous one
            image_size  <= '0;
            image_ready <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            if (image_end) begin
                image_ready <= 1'b1;  // Host may read from now on
            end

            if (byte_valid) begin
                if (size_full) begin
                    overflow <= 1'b1;  // Byte dropped by the packer
                end else begin
                    image_size <= image_size + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/byte_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_reader
    import image_buffer_pkg::*;
(
    input  logic        clock_in,
    input  logic        rst,
    input  logic        read_enable,
    input  byte_addr_t  read_address,
    input  word_t       read_word,
    input  image_size_t image_size,
    output logic        read_valid,
    output byte_t       read_data
);

    logic  stage_valid;     // Read in flight, RAM word arrives this cycle
    lane_t stage_lane;      // Lane of that read
    logic  stage_in_range;  // Address was below the image size
    byte_t lane_byte;       // Addressed byte of the RAM word

    // Valid pipeline, two stages to line up with the RAM read
    always_ff @(posedge clock_in) begin
        if (rst) begin
            stage_valid <= 1'b0;
            read_valid  <= 1'b0;
        end else begin
            stage_valid <= read_enable;
            read_valid  <= stage_valid;
        end
    end

    // First stage captures what the second stage needs
    always_ff @(posedge clock_in) begin
        stage_lane     <= read_address[1:0];
        stage_in_range <= ({1'b0, read_address} < image_size);
    end

    // Lane 0 is the low byte
    always_comb begin
        case (stage_lane)
            2'd0: lane_byte = read_word[7:0];
            2'd1: lane_byte = read_word[15:8];
            2'd2: lane_byte = read_word[23:16];
            2'd3: lane_byte = read_word[31:24];
            default: lane_byte = '0;
        endcase
    end

    // Second stage, blank anything past the end of the image
    always_ff @(posedge clock_in) begin
        if (stage_in_range) begin
            read_data <= lane_byte;
        end else begin
            read_data <= '0;
        end
    end

endmodule

`default_nettype wire

/* src/image_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module image_buffer
    import image_buffer_pkg::*;
(
    input  logic        clock_in,
    input  logic        rst,

    // Encoder side
    input  logic        image_start,
    input  logic        image_end,
    input  logic        byte_valid,
    input  byte_t       byte_data,

    // Host side
    input  logic        read_enable,
    input  byte_addr_t  read_address,
    output byte_t       read_data,
    output logic        read_valid,

    // Status
    output logic        image_ready,
    output logic        overflow,
    output image_size_t image_size
);

    logic       write_enable;   // Packer to RAM
    word_addr_t write_address;
    word_t      write_data;
    word_t      read_word;      // RAM to reader

    word_packer word_packer_i (
        .clock_in      (clock_in),
        .rst           (rst),
        .image_start   (image_start),
        .image_end     (image_end),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data)
    );

    buffer_ram buffer_ram_i (
        .clock_in      (clock_in),
        .write_enable  (write_enable),
        .write_address (write_address),
        .read_address  (read_address[15:2]),  // Word part of the byte address
        .write_data    (write_data),
        .read_word     (read_word)
    );

    capture_tracker capture_tracker_i (
        .clock_in    (clock_in),
        .rst         (rst),
        .image_start (image_start),
        .image_end   (image_end),
        .byte_valid  (byte_valid),
        .image_size  (image_size),
        .image_ready (image_ready),
        .overflow    (overflow)
    );

    byte_reader byte_reader_i (
        .clock_in     (clock_in),
        .rst          (rst),
        .read_enable  (read_enable),
        .read_address (read_address),
        .read_word    (read_word),
        .image_size   (image_size),  // Also the top-level status output
        .read_valid   (read_valid),
        .read_data    (read_data)
    );

endmodule

`default_nettype wire

/* sim/tb_image_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_image_buffer
    import image_buffer_pkg::*;
();

    localparam int ready_timeout = 64;    // Cycles allowed from image_end to ready
    localparam int drain_timeout = 4096;  // Cycles allowed for pending reads
    localparam int order_depth   = 2048;  // Room for the shuffled address list

    logic        clock_in = 1'b0;
    logic        rst;
    logic        image_start;
    logic        image_end;
    logic        byte_valid;
    byte_t       byte_data;
    logic        read_enable;
    byte_addr_t  read_address;
    byte_t       read_data;
    logic        read_valid;
    logic        image_ready;
    logic        overflow;
    image_size_t image_size;

    logic [15:0] lfsr_state = 16'd39017;
    byte_t       model [0:bytes_per_buffer-1];  // Bytes of the current image
    int          model_size;
    logic        model_overflow;                // A byte arrived with the buffer full
    byte_t       expected_reads [$];            // Pushed at issue and popped at read_valid
    logic [1:0]  enable_history = 2'b00;        // read_enable of the last two cycles
    int          read_order [0:order_depth-1];
    int          value_errors;
    int          other_errors;

    always #4 clock_in = ~clock_in;

    image_buffer image_buffer_i (
        .clock_in     (clock_in),
        .rst          (rst),
        .image_start  (image_start),
        .image_end    (image_end),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .read_enable  (read_enable),
        .read_address (read_address),
        .read_data    (read_data),
        .read_valid   (read_valid),
        .image_ready  (image_ready),
        .overflow     (overflow),
        .image_size   (image_size)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic int random_bits(input int count);
        int   value;
        int   i;
        logic feedback;
        value = 0;
        for (i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = (value << 1) | int'(feedback);
        end
        return value;
    endfunction

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_size(input string name, input image_size_t expected,
                              input image_size_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // Pulse image_start and confirm the status is cleared
    task automatic start_image();
        @(posedge clock_in);
        image_start    <= 1'b1;
        model_size     = 0;
        model_overflow = 1'b0;
        @(posedge clock_in);
        image_start <= 1'b0;
        @(negedge clock_in);
        check_flag("image_ready", 1'b0, image_ready);
        check_flag("overflow", 1'b0, overflow);
        check_size("image_size", '0, image_size);
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        @(negedge clock_in);
        while (image_ready !== 1'b1 && cycles < ready_timeout) begin
            @(negedge clock_in);
            cycles++;
        end
        if (image_ready !== 1'b1) begin
            report_failure("image_ready never rose after image_end");
        end else if (cycles != 0) begin
            report_failure("image_ready rose later than one cycle after image_end");
        end
    endtask

    task automatic send_image(input int length, input bit with_gaps);
        int    i;
        int    gap;
        byte_t value;
        start_image();
        for (i = 0; i < length; i++) begin
            value = byte_t'(random_bits(8));
            @(posedge clock_in);
            byte_valid <= 1'b1;
            byte_data  <= value;
            if (model_size < bytes_per_buffer) begin
                model[model_size] = value;
                model_size++;
            end else begin
                model_overflow = 1'b1;
            end
            if (with_gaps) begin
                gap = random_bits(2);
                repeat (gap) begin
                    @(posedge clock_in);
                    byte_valid <= 1'b0;
                end
            end
        end
        @(posedge clock_in);
        byte_valid <= 1'b0;
        image_end  <= 1'b1;
        @(posedge clock_in);
        image_end <= 1'b0;
        wait_for_ready();
    endtask

    task automatic check_status();
        check_size("image_size", image_size_t'(model_size), image_size);
        check_flag("overflow", model_overflow, overflow);
    endtask

    task automatic issue_read(input byte_addr_t address);
        @(posedge clock_in);
        read_enable  <= 1'b1;
        read_address <= address;
        if (int'(address) < model_size) begin
            expected_reads.push_back(model[address]);
        end else begin
            expected_reads.push_back(8'h00);  // Past the end reads as zero
        end
    endtask

    task automatic idle_read();
        @(posedge clock_in);
        read_enable <= 1'b0;
    endtask

    task automatic finish_reads();
        int cycles;
        cycles = 0;
        idle_read();
        while (expected_reads.size() != 0 && cycles < drain_timeout) begin
            @(negedge clock_in);
            cycles++;
        end
        if (expected_reads.size() != 0) begin
            report_failure("read results still missing after the reads ended");
            expected_reads.delete();
        end
    endtask

    // read_valid follows read_enable by two cycles and results come back in issue order
    always @(negedge clock_in) begin
        if (rst) begin
            enable_history = 2'b00;
        end else begin
            check_flag("read_valid", enable_history[1], read_valid);
            if (read_valid === 1'b1) begin
                if (expected_reads.size() == 0) begin
                    report_failure("read_valid came with no read pending");
                end else begin
                    check_byte("read_data", expected_reads.pop_front(), read_data);
                end
            end
            enable_history = {enable_history[0], read_enable};
        end
    end

    initial begin
        int length;
        int i;
        int j;
        int held;
        rst            <= 1'b1;
        image_start    <= 1'b0;
        image_end      <= 1'b0;
        byte_valid     <= 1'b0;
        byte_data      <= '0;
        read_enable    <= 1'b0;
        read_address   <= '0;
        value_errors   = 0;
        other_errors   = 0;
        model_size     = 0;
        model_overflow = 1'b0;

        repeat (10) @(posedge clock_in);
        rst <= 1'b0;
        @(negedge clock_in);
        check_flag("read_valid", 1'b0, read_valid);
        check_flag("image_ready", 1'b0, image_ready);
        check_flag("overflow", 1'b0, overflow);
        check_size("image_size", '0, image_size);

        // First image with a length that leaves the last word partial
        length = 200 + random_bits(10);
        if (length % 4 == 0) begin
            length++;
        end
        send_image(length, 1'b1);
        check_status();

        // Every address once in shuffled order
        for (i = 0; i < model_size; i++) begin
            read_order[i] = i;
        end
        for (i = model_size - 1; i > 0; i--) begin
            j             = random_bits(16) % (i + 1);
            held          = read_order[i];
            read_order[i] = read_order[j];
            read_order[j] = held;
        end
        for (i = 0; i < model_size; i++) begin
            issue_read(byte_addr_t'(read_order[i]));
            if (random_bits(1) == 1) begin
                idle_read();
            end
        end
        finish_reads();

        // Back-to-back burst
        for (i = 0; i < 64; i++) begin
            issue_read(byte_addr_t'(random_bits(16) % model_size));
        end
        finish_reads();

        // At and past the end of the image
        issue_read(byte_addr_t'(model_size));
        issue_read(byte_addr_t'(model_size + 1));
        for (i = 0; i < 32; i++) begin
            issue_read(byte_addr_t'(model_size + random_bits(16) % (bytes_per_buffer - model_size)));
        end
        issue_read(16'hffff);
        finish_reads();

        // Second and shorter image over the old contents
        length = 1 + random_bits(6);
        if (length % 4 == 0) begin
            length++;
        end
        send_image(length, 1'b1);
        check_status();
        for (i = 0; i < model_size + 8; i++) begin
            issue_read(byte_addr_t'(i));
        end
        finish_reads();

        // Four bytes more than the buffer holds
        send_image(bytes_per_buffer + 4, 1'b0);
        check_status();
        issue_read(16'h0000);
        issue_read(16'hffff);
        for (i = 0; i < 256; i++) begin
            issue_read(byte_addr_t'(random_bits(16)));
        end
        finish_reads();

        // Overflow and ready both clear on the next image_start
        start_image();

        $display("Run complete with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/image_buffer_pkg.sv
src/word_packer.sv
src/buffer_ram.sv
src/capture_tracker.sv
src/byte_reader.sv
src/image_buffer.sv
sim/tb_image_buffer.sv

/* Makefile */
# Verilator build and run of the image buffer testbench

SOURCES = src/image_buffer_pkg.sv src/word_packer.sv src/buffer_ram.sv \
          src/capture_tracker.sv src/byte_reader.sv src/image_buffer.sv \
          sim/tb_image_buffer.sv

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
obj_dir/Vtb_image_buffer: vlog.f $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ns -j 0 \
		--top-module tb_image_buffer -f vlog.f

# Fails unless the pass line shows up in the output
run: obj_dir/Vtb_image_buffer
	@out="$$(./obj_dir/Vtb_image_buffer)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir
